//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f bitcore_top.f \
		--top-module bitcore_tb -Mdir obj_dir -o bitcore_sim

run: compile
	./obj_dir/bitcore_sim | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bitcore_top.f
+incdir+rtl
rtl/bitcore_pkg.sv
rtl/bus_if.sv
rtl/bitcore_control.sv
rtl/bitcore_alu.sv
rtl/bitcore_regfile.sv
rtl/bitcore_mem_if.sv
rtl/bus_arbiter.sv
rtl/bitcore_top.sv
test/bitcore_checker.sv
test/bitcore_tb.sv

//--- rtl/bitcore_alu.sv
`timescale 1ns/1ns

module bitcore_alu (
   input  logic                 clk,
   input  logic                 i_rst,
   input  logic                 i_en,
   input  logic                 i_first,
   input  logic                 i_rs1,
   input  logic                 i_op_b,
   input  logic                 i_sub,
   input  bitcore_pkg::alu_op_t i_op,
   output logic                 o_rd,
   output logic                 o_eq
);
   logic carry_r;
   logic eq_r;
   logic b_inv;
   logic carry_in;
   logic sum;

   // Two's complement subtract inverts B and carries one into bit 0
   assign b_inv    = i_op_b ^ i_sub;
   assign carry_in = i_first ? i_sub : carry_r;
   assign sum      = i_rs1 ^ b_inv ^ carry_in;

   always_comb begin
      case (i_op)
         bitcore_pkg::ALU_AND: o_rd = i_rs1 & i_op_b;
         bitcore_pkg::ALU_OR:  o_rd = i_rs1 | i_op_b;
         bitcore_pkg::ALU_XOR: o_rd = i_rs1 ^ i_op_b;
         default:              o_rd = sum;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         carry_r <= 1'b0;
         eq_r    <= 1'b0;
      end else if (i_en) begin
         carry_r <= (i_rs1 & b_inv) | (carry_in & (i_rs1 ^ b_inv));
         // Restart the compare on bit 0
         eq_r    <= (i_first | eq_r) & (i_rs1 == i_op_b);
      end
   end

   assign o_eq = eq_r;
endmodule

//--- rtl/bitcore_control.sv
`timescale 1ns/1ns
`include "bitcore_defs.svh"

module bitcore_control (
   input  logic                          clk,
   input  logic                          i_rst,
   bus_if.master                         ibus,
   input  logic                          i_alu_eq,
   input  logic                          i_mem_done,
   output logic                          o_cnt_en,
   output logic [`BITCORE_CNT_W-1:0]     o_cnt,
   output bitcore_pkg::reg_addr_t        o_rs1_addr,
   output bitcore_pkg::reg_addr_t        o_rs2_addr,
   output bitcore_pkg::reg_addr_t        o_rd_addr,
   output logic                          o_rd_en,
   output bitcore_pkg::alu_op_t          o_alu_op,
   output logic                          o_alu_sub,
   output logic                          o_op_b_imm,
   output logic                          o_imm,
   output logic                          o_rd_sel_mem,
   output logic                          o_mem_start,
   output logic                          o_mem_we,
   output logic                          o_wback
);
   bitcore_pkg::ctrl_state_t state;
   bitcore_pkg::word_t       instr;
   bitcore_pkg::word_t       pc;
   bitcore_pkg::word_t       pc_plus4;
   bitcore_pkg::word_t       pc_target;
   bitcore_pkg::word_t       imm_ser;
   logic [`BITCORE_CNT_W-1:0] cnt;
   logic                     cyc_r;
   logic                     br_pend;
   logic                     br_taken;
   logic                     cnt_last;
   logic [2:0]               funct3;
   logic                     is_opimm, is_op, is_lui, is_load, is_store, is_branch, is_jal;

   assign funct3    = instr[14:12];
   assign is_opimm  = instr[6:0] == 7'b0010011;
   assign is_op     = instr[6:0] == 7'b0110011;
   assign is_lui    = instr[6:0] == 7'b0110111;
   assign is_load   = instr[6:0] == 7'b0000011;
   assign is_store  = instr[6:0] == 7'b0100011;
   assign is_branch = instr[6:0] == 7'b1100011;
   assign is_jal    = instr[6:0] == 7'b1101111;

   // Parallel PC adder with a J or B offset
   assign pc_plus4  = pc + 32'd4;
   assign pc_target = pc + (is_jal ?
      {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0} :
      {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0});

   // BEQ on funct3 000, BNE on 001
   assign br_taken = funct3[0] ? !i_alu_eq : i_alu_eq;

   // Word fed to the ALU one bit per cycle
   always_comb begin
      if (is_lui)
         imm_ser = {instr[31:12], 12'b0};
      else if (is_store)
         imm_ser = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      else if (is_jal)
         imm_ser = pc_plus4;
      else
         imm_ser = {{20{instr[31]}}, instr[31:20]};
   end

   always_comb begin
      o_alu_op = bitcore_pkg::ALU_SUM;
      if (is_opimm | is_op) begin
         case (funct3)
            3'b100:  o_alu_op = bitcore_pkg::ALU_XOR;
            3'b110:  o_alu_op = bitcore_pkg::ALU_OR;
            3'b111:  o_alu_op = bitcore_pkg::ALU_AND;
            default: o_alu_op = bitcore_pkg::ALU_SUM;
         endcase
      end
   end

   assign cnt_last     = &cnt;
   assign o_cnt        = cnt;
   assign o_cnt_en     = (state == bitcore_pkg::EXEC) | (state == bitcore_pkg::WBACK);
   // LUI and JAL add to x0
   assign o_rs1_addr   = (is_lui | is_jal) ? 5'd0 : instr[19:15];
   assign o_rs2_addr   = instr[24:20];
   assign o_rd_addr    = instr[11:7];
   assign o_rd_en      = ((state == bitcore_pkg::EXEC) & (is_opimm | is_op | is_lui | is_jal))
                         | (state == bitcore_pkg::WBACK);
   assign o_alu_sub    = is_op & instr[30] & (funct3 == 3'b000);
   assign o_op_b_imm   = !(is_op | is_branch);
   assign o_imm        = imm_ser[cnt];
   assign o_rd_sel_mem = state == bitcore_pkg::WBACK;
   assign o_wback      = state == bitcore_pkg::WBACK;
   assign o_mem_start  = state == bitcore_pkg::MEM;
   assign o_mem_we     = is_store;

   assign ibus.adr = pc;
   assign ibus.dat = '0;
   assign ibus.we  = 1'b0;
   assign ibus.cyc = cyc_r;

   always_ff @(posedge clk) begin
      if (ibus.cyc & ibus.ack)
         instr <= ibus.rdt;
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state   <= bitcore_pkg::FETCH;
         cnt     <= '0;
         pc      <= `BITCORE_RESET_PC;
         cyc_r   <= 1'b0;
         br_pend <= 1'b0;
      end else begin
         if (ibus.ack)
            cyc_r <= 1'b0;
         else if (state == bitcore_pkg::FETCH)
            cyc_r <= 1'b1;
         case (state)
            bitcore_pkg::FETCH: begin
               // Branch outcome is ready one cycle after the last bit
               if (br_pend) begin
                  pc      <= br_taken ? pc_target : pc_plus4;
                  br_pend <= 1'b0;
               end
               if (ibus.cyc & ibus.ack)
                  state <= bitcore_pkg::DECODE;
            end
            bitcore_pkg::DECODE: begin
               state <= bitcore_pkg::EXEC;
            end
            bitcore_pkg::EXEC: begin
               cnt <= cnt + 1'b1;
               if (cnt_last) begin
                  if (is_branch)
                     br_pend <= 1'b1;
                  else
                     pc <= is_jal ? pc_target : pc_plus4;
                  state <= (is_load | is_store) ? bitcore_pkg::MEM : bitcore_pkg::FETCH;
               end
            end
            bitcore_pkg::MEM: begin
               if (i_mem_done)
                  state <= is_load ? bitcore_pkg::WBACK : bitcore_pkg::FETCH;
            end
            bitcore_pkg::WBACK: begin
               cnt <= cnt + 1'b1;
               if (cnt_last)
                  state <= bitcore_pkg::FETCH;
            end
            default: state <= bitcore_pkg::FETCH;
         endcase
      end
   end
endmodule

//--- rtl/bitcore_defs.svh
`ifndef BITCORE_DEFS_SVH
`define BITCORE_DEFS_SVH

// Address of the first instruction fetch
`define BITCORE_RESET_PC 32'h0000_0000

// Serial bit counter with one step per data bit of a 32-bit word
`define BITCORE_CNT_W 5

`endif

//--- rtl/bitcore_mem_if.sv
`timescale 1ns/1ns

module bitcore_mem_if (
   input  logic  clk,
   input  logic  i_rst,
   input  logic  i_en,
   input  logic  i_addr_bit,
   input  logic  i_rs2,
   input  logic  i_start,
   input  logic  i_we,
   input  logic  i_wback,
   bus_if.master dbus,
   output logic  o_done,
   output logic  o_rd
);
   bitcore_pkg::word_t adr_r;
   bitcore_pkg::word_t dat_r;
   bitcore_pkg::word_t ld_r;
   logic               cyc_r;
   logic               shift_in;

   assign shift_in = i_en & !i_wback;

   // LSB first so bit 0 ends up at the bottom after 32 shifts
   always_ff @(posedge clk) begin
      if (shift_in) begin
         adr_r <= {i_addr_bit, adr_r[31:1]};
         dat_r <= {i_rs2, dat_r[31:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (dbus.cyc & dbus.ack & !i_we)
         ld_r <= dbus.rdt;
      else if (i_en & i_wback)
         ld_r <= {1'b0, ld_r[31:1]};
   end

   always_ff @(posedge clk) begin
      if (i_rst)
         cyc_r <= 1'b0;
      else if (dbus.ack)
         cyc_r <= 1'b0;
      else if (i_start)
         cyc_r <= 1'b1;
   end

   // Word accesses only
   assign dbus.adr = {adr_r[31:2], 2'b00};
   assign dbus.dat = dat_r;
   assign dbus.we  = cyc_r & i_we;
   assign dbus.cyc = cyc_r;

   assign o_done = dbus.cyc & dbus.ack;
   assign o_rd   = ld_r[0];
endmodule

//--- rtl/bitcore_pkg.sv
package bitcore_pkg;

   // Instructions, addresses and data
   typedef logic [31:0] word_t;

   typedef logic [4:0] reg_addr_t;

   // ALU result select
   typedef logic [1:0] alu_op_t;

   localparam alu_op_t ALU_SUM = 2'd0;
   localparam alu_op_t ALU_AND = 2'd1;
   localparam alu_op_t ALU_OR  = 2'd2;
   localparam alu_op_t ALU_XOR = 2'd3;

   // One instruction at a time
   typedef enum logic [2:0] {
      FETCH,
      DECODE,
      EXEC,
      MEM,
      WBACK
   } ctrl_state_t;

endpackage

//--- rtl/bitcore_regfile.sv
`timescale 1ns/1ns
`include "bitcore_defs.svh"

module bitcore_regfile (
   input  logic                      clk,
   input  logic                      i_rst,
   input  logic [`BITCORE_CNT_W-1:0] i_cnt,
   input  bitcore_pkg::reg_addr_t    i_rs1_addr,
   input  bitcore_pkg::reg_addr_t    i_rs2_addr,
   input  bitcore_pkg::reg_addr_t    i_rd_addr,
   input  logic                      i_rd_en,
   input  logic                      i_rd,
   output logic                      o_rs1,
   output logic                      o_rs2
);
   // No storage for x0
   bitcore_pkg::word_t regs [1:31];
   logic               wr_en;

   assign wr_en = i_rd_en & (i_rd_addr != 5'd0) & !i_rst;

   always_ff @(posedge clk) begin
      if (wr_en)
         regs[i_rd_addr][i_cnt] <= i_rd;
   end

   // x0 reads as zero
   assign o_rs1 = (i_rs1_addr == 5'd0) ? 1'b0 : regs[i_rs1_addr][i_cnt];
   assign o_rs2 = (i_rs2_addr == 5'd0) ? 1'b0 : regs[i_rs2_addr][i_cnt];
endmodule

//--- rtl/bitcore_top.sv
`timescale 1ns/1ns
`include "bitcore_defs.svh"

module bitcore_top (
   input  logic               clk,
   input  logic               i_rst,
   output bitcore_pkg::word_t o_mem_adr,
   output bitcore_pkg::word_t o_mem_dat,
   output logic               o_mem_we,
   output logic               o_mem_cyc,
   input  bitcore_pkg::word_t i_mem_rdt,
   input  logic               i_mem_ack
);
   logic                      cnt_en;
   logic [`BITCORE_CNT_W-1:0] cnt;
   bitcore_pkg::reg_addr_t    rs1_addr;
   bitcore_pkg::reg_addr_t    rs2_addr;
   bitcore_pkg::reg_addr_t    rd_addr;
   logic                      rd_en;
   bitcore_pkg::alu_op_t      alu_op;
   logic                      alu_sub;
   logic                      alu_eq;
   logic                      alu_rd;
   logic                      op_b_imm;
   logic                      imm;
   logic                      op_b;
   logic                      rs1;
   logic                      rs2;
   logic                      rd;
   logic                      rd_sel_mem;
   logic                      mem_start;
   logic                      mem_we;
   logic                      mem_done;
   logic                      mem_rd;
   logic                      wback;

   bus_if ibus ();
   bus_if dbus ();

   // Serial operand and writeback selects
   assign op_b = op_b_imm ? imm : rs2;
   assign rd   = rd_sel_mem ? mem_rd : alu_rd;

   bitcore_control control0 (
      .clk(clk), .i_rst(i_rst), .ibus(ibus),
      .i_alu_eq(alu_eq), .i_mem_done(mem_done),
      .o_cnt_en(cnt_en), .o_cnt(cnt),
      .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_rd_addr(rd_addr), .o_rd_en(rd_en),
      .o_alu_op(alu_op), .o_alu_sub(alu_sub), .o_op_b_imm(op_b_imm), .o_imm(imm),
      .o_rd_sel_mem(rd_sel_mem), .o_mem_start(mem_start), .o_mem_we(mem_we), .o_wback(wback)
   );

   bitcore_alu alu0 (
      .clk(clk), .i_rst(i_rst), .i_en(cnt_en), .i_first(cnt == '0),
      .i_rs1(rs1), .i_op_b(op_b), .i_sub(alu_sub), .i_op(alu_op),
      .o_rd(alu_rd), .o_eq(alu_eq)
   );

   bitcore_regfile regfile0 (
      .clk(clk), .i_rst(i_rst), .i_cnt(cnt),
      .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr), .i_rd_addr(rd_addr),
      .i_rd_en(rd_en), .i_rd(rd), .o_rs1(rs1), .o_rs2(rs2)
   );

   bitcore_mem_if mem_if0 (
      .clk(clk), .i_rst(i_rst), .i_en(cnt_en), .i_addr_bit(alu_rd), .i_rs2(rs2),
      .i_start(mem_start), .i_we(mem_we), .i_wback(wback), .dbus(dbus),
      .o_done(mem_done), .o_rd(mem_rd)
   );

   bus_arbiter arbiter0 (
      .clk(clk), .i_rst(i_rst), .ibus(ibus), .dbus(dbus),
      .o_mem_adr(o_mem_adr), .o_mem_dat(o_mem_dat), .o_mem_we(o_mem_we),
      .o_mem_cyc(o_mem_cyc), .i_mem_rdt(i_mem_rdt), .i_mem_ack(i_mem_ack)
   );
endmodule

//--- rtl/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter (
   input  logic               clk,
   input  logic               i_rst,
   bus_if.slave               ibus,
   bus_if.slave               dbus,
   output bitcore_pkg::word_t o_mem_adr,
   output bitcore_pkg::word_t o_mem_dat,
   output logic               o_mem_we,
   output logic               o_mem_cyc,
   input  bitcore_pkg::word_t i_mem_rdt,
   input  logic               i_mem_ack
);
   logic locked;
   logic own_d;
   logic sel_d;

   // Data master wins unless a transfer is already in flight
   assign sel_d = locked ? own_d : dbus.cyc;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         locked <= 1'b0;
         own_d  <= 1'b0;
      end else if (o_mem_cyc & i_mem_ack) begin
         locked <= 1'b0;
      end else if (o_mem_cyc) begin
         locked <= 1'b1;
         own_d  <= sel_d;
      end
   end

   assign o_mem_adr = sel_d ? dbus.adr : ibus.adr;
   assign o_mem_dat = sel_d ? dbus.dat : ibus.dat;
   assign o_mem_we  = sel_d ? dbus.we  : ibus.we;
   assign o_mem_cyc = sel_d ? dbus.cyc : ibus.cyc;

   assign ibus.rdt = i_mem_rdt;
   assign dbus.rdt = i_mem_rdt;
   assign ibus.ack = !sel_d & i_mem_ack;
   assign dbus.ack = sel_d & i_mem_ack;
endmodule

//--- rtl/bus_if.sv
`timescale 1ns/1ns

interface bus_if;
   bitcore_pkg::word_t adr;
   bitcore_pkg::word_t dat;
   logic               we;
   logic               cyc;
   bitcore_pkg::word_t rdt;
   logic               ack;

   modport master (
      output adr, dat, we, cyc,
      input  rdt, ack
   );

   modport slave (
      input  adr, dat, we, cyc,
      output rdt, ack
   );
endinterface

//--- test/bitcore_checker.sv
`timescale 1ns/1ns

module bitcore_checker (
   input logic               clk,
   input logic               i_rst,
   input bitcore_pkg::word_t o_mem_adr,
   input bitcore_pkg::word_t o_mem_dat,
   input logic               o_mem_we,
   input logic               o_mem_cyc,
   input logic               i_mem_ack
);
   // Request held steady until acknowledged
   hold_until_ack: assert property (@(posedge clk) disable iff (i_rst)
      o_mem_cyc && !i_mem_ack |=> o_mem_cyc && $stable(o_mem_adr)
                                  && $stable(o_mem_dat) && $stable(o_mem_we))
      else $error("memory request changed before ack");

   we_needs_cyc: assert property (@(posedge clk) disable iff (i_rst) o_mem_we |-> o_mem_cyc)
      else $error("write enable high without cyc");

   cyc_low_in_reset: assert property (@(posedge clk) i_rst |=> !o_mem_cyc)
      else $error("cyc high after reset");
endmodule

bind bitcore_top bitcore_checker checker0 (
   .clk(clk), .i_rst(i_rst), .o_mem_adr(o_mem_adr), .o_mem_dat(o_mem_dat),
   .o_mem_we(o_mem_we), .o_mem_cyc(o_mem_cyc), .i_mem_ack(i_mem_ack)
);

//--- test/bitcore_stim.txt
// Hex words, @ gives the word index (byte address / 4); words 0-255 are the memory image
// From word 0x100: store count, then one store per line as address and data
@00
5A300093 F1000113  // addi x1 0x5a3, addi x2 -0xf0
002081B3 40208233  // add x3, sub x4
0020F2B3 0020E333  // and x5, or x6
0020C3B3 12345437  // xor x7, lui x8
18302023 18402223  // store x3 and x4
18502423 18602623  // store x5 and x6
18702823 18802A23  // store x7 and x8
10002483 18902C23  // lw x9 from 0x100, store x9
07700013 18002E23  // addi x0, store x0
00108463 1E102823  // beq taken, skipped word
00109463 1A102023  // bne not taken, store x1
00209463 1E102823  // bne taken, skipped word
00208463 1A202223  // beq not taken, store x2
0080056F 1E102823  // jal x10, skipped word
1AA02423 0000006F  // store x10, spin
@40
13579BDF
@100
0000000B
00000180 000004B3
00000184 00000693
00000188 00000500
0000018C FFFFFFB3
00000190 FFFFFAB3
00000194 12345000
00000198 13579BDF
0000019C 00000000
000001A0 000005A3
000001A4 FFFFFF10
000001A8 0000006C

//--- test/bitcore_tb.sv
`timescale 1ns/1ns
`include "bitcore_defs.svh"

module bitcore_tb;
   // Word index of the store trace in the stim image
   localparam int TRACE_BASE = 256;
   // SW x1, 0x1f0(x0) fills every word that a branch or jump must skip
   localparam bitcore_pkg::word_t SKIP_INSN = 32'h1E10_2823;

   logic               clk = 1'b0;
   logic               i_rst = 1'b1;
   bitcore_pkg::word_t mem_adr;
   bitcore_pkg::word_t mem_dat;
   logic               mem_we;
   logic               mem_cyc;
   bitcore_pkg::word_t mem_rdt = '0;
   logic               mem_ack = 1'b0;
   bitcore_pkg::word_t stim [0:383];
   bitcore_pkg::word_t mem [0:255];
   bitcore_pkg::word_t st_adr [$];
   bitcore_pkg::word_t st_dat [$];
   int                 delay_left = 0;
   int                 skip_hits = 0;
   int                 reads = 0;
   int                 errors = 0;
   int                 tests = 0;
   int                 failed_tests = 0;

   bitcore_top dut0 (
      .clk(clk), .i_rst(i_rst),
      .o_mem_adr(mem_adr), .o_mem_dat(mem_dat), .o_mem_we(mem_we), .o_mem_cyc(mem_cyc),
      .i_mem_rdt(mem_rdt), .i_mem_ack(mem_ack)
   );

   always #50 clk = ~clk;

   // Memory model acks after 0 to 3 idle cycles
   always @(posedge clk) begin
      if (i_rst) begin
         mem_ack <= 1'b0;
      end else if (mem_ack) begin
         mem_ack <= 1'b0;
      end else if (mem_cyc) begin
         if (delay_left == 0) begin
            mem_ack <= 1'b1;
            mem_rdt <= mem[mem_adr[9:2]];
            if (mem_we) begin
               mem[mem_adr[9:2]] = mem_dat;
               st_adr.push_back(mem_adr);
               st_dat.push_back(mem_dat);
            end else begin
               reads++;
               if (mem[mem_adr[9:2]] == SKIP_INSN)
                  skip_hits++;
            end
            delay_left = $urandom % 4;
         end else begin
            delay_left--;
         end
      end
   end

   task automatic finish_test(input string name, input int errs_before);
      tests++;
      if (errors > errs_before) begin
         failed_tests++;
         $display("%s: failed", name);
      end else begin
         $display("%s: ok", name);
      end
   endtask

   task automatic verify_reset_fetch();
      int   n;
      int   start;
      logic early_we;
      start = errors;
      n = 0;
      early_we = 1'b0;
      @(negedge clk);
      while (!mem_cyc && n < 100) begin
         if (mem_we)
            early_we = 1'b1;
         @(negedge clk);
         n++;
      end
      if (!mem_cyc) begin
         $display("reset fetch: no bus request within 100 cycles of reset");
         errors++;
      end else if (mem_adr !== `BITCORE_RESET_PC) begin
         $display("** Error at %0t: o_mem_adr = %h, expected %h",
                  $time, mem_adr, `BITCORE_RESET_PC);
         errors++;
      end
      if (early_we || mem_we) begin
         $display("reset fetch: write enable was high before or at the first fetch");
         errors++;
      end
      finish_test("reset fetch", start);
   endtask

   task automatic compare_stores(input string name, input int first, input int last);
      int n;
      int start;
      start = errors;
      n = 0;
      while (st_adr.size() <= last && n < 2000) begin
         @(negedge clk);
         n++;
      end
      if (st_adr.size() <= last) begin
         $display("%s: timed out waiting for store %0d", name, st_adr.size());
         errors++;
      end else begin
         for (int i = first; i <= last; i++) begin
            if (st_adr[i] !== stim[TRACE_BASE + 1 + 2 * i]) begin
               $display("** Error at %0t: o_mem_adr = %h, expected %h",
                        $time, st_adr[i], stim[TRACE_BASE + 1 + 2 * i]);
               errors++;
            end
            if (st_dat[i] !== stim[TRACE_BASE + 2 + 2 * i]) begin
               $display("** Error at %0t: o_mem_dat = %h, expected %h",
                        $time, st_dat[i], stim[TRACE_BASE + 2 + 2 * i]);
               errors++;
            end
         end
      end
      finish_test(name, start);
   endtask

   task automatic confirm_trace_end();
      int n;
      int start;
      int reads_before;
      start = errors;
      n = 0;
      reads_before = reads;
      // Let the spin loop fetch a few times so a late store would show up
      while (reads < reads_before + 4 && n < 1000) begin
         @(negedge clk);
         n++;
      end
      if (reads < reads_before + 4) begin
         $display("trace end: the core stopped fetching after the last store");
         errors++;
      end
      if (skip_hits != 0) begin
         $display("trace end: fetch entered a skipped word %0d times", skip_hits);
         errors++;
      end
      if (st_adr.size() != stim[TRACE_BASE]) begin
         $display("** Error at %0t: store count = %0d, expected %0d",
                  $time, st_adr.size(), stim[TRACE_BASE]);
         errors++;
      end
      finish_test("trace end", start);
   endtask

   initial begin
      void'($urandom(79016));
      for (int i = 0; i < 384; i++)
         stim[i] = 32'hF111_0000 ^ (i * 4);
      $readmemh("test/bitcore_stim.txt", stim);
      for (int i = 0; i < 256; i++)
         mem[i] = stim[i];
      repeat (5) @(posedge clk);
      i_rst <= 1'b0;
      verify_reset_fetch();
      compare_stores("alu results", 0, 5);
      compare_stores("load and store", 6, 6);
      compare_stores("x0 write", 7, 7);
      compare_stores("branches and jal", 8, 10);
      confirm_trace_end();
      $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

   // Last store must land well before this
   initial begin
      #2_000_000;
      $display("global time limit reached before the store trace finished");
      $display("TEST FAIL");
      $finish;
   end
endmodule
